// ==== rtl/rv_pkg.sv ====
// RV32I subset definitions shared by the pipeline stages and the testbench
`default_nettype none

package rv_pkg;

    // Data and instruction width, fixed by the ISA
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASSB  // LUI, operand b straight through
    } alu_op_t;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } result_src_t;

    // Major opcodes
    localparam logic [6:0] OPC_RTYPE  = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

endpackage

`default_nettype wire

// ==== rtl/register_file.sv ====
// Register file with 32 entries, two read ports and a write-through write port
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2_addr,
    input  logic                          i_we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd_addr,
    input  logic [rv_pkg::XLEN-1:0]       i_rd_data,
    output logic [rv_pkg::XLEN-1:0]       o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]       o_rs2_data
);
    import rv_pkg::*;

    // No storage behind x0
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge i_clk) begin
        if (i_we && i_rd_addr != '0) begin
            regs[i_rd_addr] <= i_rd_data;
        end
    end

    // Same-cycle write is bypassed to the readers
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 :
                        (i_we && i_rs1_addr == i_rd_addr) ? i_rd_data : regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 :
                        (i_we && i_rs2_addr == i_rd_addr) ? i_rd_data : regs[i_rs2_addr];

    // A write aimed at x0 must not show up on the next read of x0
    assert property (@(posedge i_clk) disable iff (i_rst)
        (i_we && i_rd_addr == '0) |=> (i_rs1_addr != '0 || o_rs1_data == '0));

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
// Decode stage: PC, fetch, instruction decode, register read and the decode/execute register
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter int P_ADDR_WIDTH = 11
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_redirect,
    input  logic [P_ADDR_WIDTH-1:0]       i_target,
    output logic [P_ADDR_WIDTH-1:0]       o_imem_addr,
    input  logic [rv_pkg::XLEN-1:0]       i_imem_rdata,
    input  logic                          i_wb_we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_wb_rd,
    input  logic [rv_pkg::XLEN-1:0]       i_wb_data,
    output logic                          o_regwrite_e,
    output logic                          o_memwrite_e,
    output logic                          o_branch_e,
    output logic                          o_branch_ne_e,
    output logic                          o_jump_e,
    output logic                          o_alusrc_e,
    output rv_pkg::alu_op_t               o_aluop_e,
    output rv_pkg::result_src_t           o_resultsrc_e,
    output logic [rv_pkg::XLEN-1:0]       o_rs1_data_e,
    output logic [rv_pkg::XLEN-1:0]       o_rs2_data_e,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs1_addr_e,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rs2_addr_e,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rd_addr_e,
    output logic [rv_pkg::XLEN-1:0]       o_imm_e,
    output logic [P_ADDR_WIDTH-1:0]       o_pc_e,
    output logic [P_ADDR_WIDTH-1:0]       o_pc4_e
);
    import rv_pkg::*;

    logic [P_ADDR_WIDTH-1:0] pc;
    logic [P_ADDR_WIDTH-1:0] pc4;
    logic [XLEN-1:0]         instr;
    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [XLEN-1:0]         rs1_data;
    logic [XLEN-1:0]         rs2_data;
    logic                    alu_ok;
    alu_op_t                 aluop_f3;
    logic                    regwrite_d;
    logic                    memwrite_d;
    logic                    branch_d;
    logic                    jump_d;
    logic                    alusrc_d;
    alu_op_t                 aluop_d;
    result_src_t             resultsrc_d;
    logic [XLEN-1:0]         imm_d;

    assign instr       = i_imem_rdata;
    assign opcode      = instr[6:0];
    assign funct3      = instr[14:12];
    assign pc4         = pc + P_ADDR_WIDTH'(4);
    assign o_imem_addr = pc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= '0;
        end else begin
            pc <= i_redirect ? i_target : pc4;
        end
    end

    register_file u_register_file (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1_addr (instr[19:15]),
        .i_rs2_addr (instr[24:20]),
        .i_we       (i_wb_we),
        .i_rd_addr  (i_wb_rd),
        .i_rd_data  (i_wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    // funct3 to ALU op, shared by register and immediate arithmetic
    always_comb begin
        alu_ok = 1'b1;
        case (funct3)
            3'b000:  aluop_f3 = (opcode == OPC_RTYPE && instr[30]) ? ALU_SUB : ALU_ADD;
            3'b111:  aluop_f3 = ALU_AND;
            3'b110:  aluop_f3 = ALU_OR;
            3'b100:  aluop_f3 = ALU_XOR;
            3'b010:  aluop_f3 = ALU_SLT;
            3'b001:  aluop_f3 = ALU_SLL;
            3'b101:  aluop_f3 = ALU_SRL;
            default: begin
                aluop_f3 = ALU_ADD;
                alu_ok   = 1'b0;
            end
        endcase
    end

    // Unknown opcodes leave every enable low and pass as a bubble
    always_comb begin
        regwrite_d  = 1'b0;
        memwrite_d  = 1'b0;
        branch_d    = 1'b0;
        jump_d      = 1'b0;
        alusrc_d    = 1'b1;
        aluop_d     = ALU_ADD;
        resultsrc_d = RES_ALU;
        imm_d       = {{20{instr[31]}}, instr[31:20]};
        case (opcode)
            OPC_RTYPE: begin
                regwrite_d = alu_ok;
                alusrc_d   = 1'b0;
                aluop_d    = aluop_f3;
            end
            OPC_ITYPE: begin
                regwrite_d = alu_ok;
                aluop_d    = aluop_f3;
            end
            OPC_LOAD: begin
                regwrite_d  = 1'b1;
                resultsrc_d = RES_MEM;
            end
            OPC_STORE: begin
                memwrite_d = 1'b1;
                imm_d      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OPC_BRANCH: begin
                branch_d = (funct3[2:1] == 2'b00);
                alusrc_d = 1'b0;
                imm_d    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            end
            OPC_JAL: begin
                regwrite_d  = 1'b1;
                jump_d      = 1'b1;
                resultsrc_d = RES_PC4;
                imm_d       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                               instr[30:21], 1'b0};
            end
            OPC_LUI: begin
                regwrite_d = 1'b1;
                aluop_d    = ALU_PASSB;
                imm_d      = {instr[31:12], 12'b0};
            end
            default: ;
        endcase
    end

    // Decode/execute enables, cleared to a bubble on reset or redirect
    always_ff @(posedge i_clk) begin
        if (i_rst || i_redirect) begin
            o_regwrite_e <= 1'b0;
            o_memwrite_e <= 1'b0;
            o_branch_e   <= 1'b0;
            o_jump_e     <= 1'b0;
        end else begin
            o_regwrite_e <= regwrite_d;
            o_memwrite_e <= memwrite_d;
            o_branch_e   <= branch_d;
            o_jump_e     <= jump_d;
        end
    end

    always_ff @(posedge i_clk) begin
        o_branch_ne_e <= funct3[0];
        o_alusrc_e    <= alusrc_d;
        o_aluop_e     <= aluop_d;
        o_resultsrc_e <= resultsrc_d;
        o_rs1_data_e  <= rs1_data;
        o_rs2_data_e  <= rs2_data;
        o_rs1_addr_e  <= instr[19:15];
        o_rs2_addr_e  <= instr[24:20];
        o_rd_addr_e   <= instr[11:7];
        o_imm_e       <= imm_d;
        o_pc_e        <= pc;
        o_pc4_e       <= pc4;
    end

    // A slot entering execute is either a register writer or a store, never both
    assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_regwrite_e && o_memwrite_e));

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
// Execute stage: operand forwarding, ALU, branch and jump resolution, execute/result register
`timescale 1ns/1ps
`default_nettype none

module execute_stage #(
    parameter int P_ADDR_WIDTH = 11
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_regwrite,
    input  logic                          i_memwrite,
    input  logic                          i_branch,
    input  logic                          i_branch_ne,
    input  logic                          i_jump,
    input  logic                          i_alusrc,
    input  rv_pkg::alu_op_t               i_aluop,
    input  rv_pkg::result_src_t           i_resultsrc,
    input  logic [rv_pkg::XLEN-1:0]       i_rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       i_rs2_data,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd_addr,
    input  logic [rv_pkg::XLEN-1:0]       i_imm,
    input  logic [P_ADDR_WIDTH-1:0]       i_pc,
    input  logic [P_ADDR_WIDTH-1:0]       i_pc4,
    input  logic                          i_fwd_we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_fwd_rd,
    input  logic [rv_pkg::XLEN-1:0]       i_fwd_data,
    output logic                          o_redirect,
    output logic [P_ADDR_WIDTH-1:0]       o_target,
    output logic [rv_pkg::XLEN-1:0]       o_alu_result_r,
    output logic [rv_pkg::XLEN-1:0]       o_store_data_r,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_rd_addr_r,
    output logic                          o_regwrite_r,
    output logic                          o_memwrite_r,
    output rv_pkg::result_src_t           o_resultsrc_r,
    output logic [rv_pkg::XLEN-1:0]       o_pc4_r
);
    import rv_pkg::*;

    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_result;
    logic            taken;

    // Result stage value replaces a stale register read
    assign src_a   = (i_fwd_we && i_fwd_rd != '0 && i_fwd_rd == i_rs1_addr) ?
                     i_fwd_data : i_rs1_data;
    assign rs2_val = (i_fwd_we && i_fwd_rd != '0 && i_fwd_rd == i_rs2_addr) ?
                     i_fwd_data : i_rs2_data;
    assign src_b   = i_alusrc ? i_imm : rs2_val;

    always_comb begin
        case (i_aluop)
            ALU_ADD:   alu_result = src_a + src_b;
            ALU_SUB:   alu_result = src_a - src_b;
            ALU_AND:   alu_result = src_a & src_b;
            ALU_OR:    alu_result = src_a | src_b;
            ALU_XOR:   alu_result = src_a ^ src_b;
            ALU_SLT:   alu_result = XLEN'($signed(src_a) < $signed(src_b));
            ALU_SLL:   alu_result = src_a << src_b[4:0];
            ALU_SRL:   alu_result = src_a >> src_b[4:0];
            ALU_PASSB: alu_result = src_b;
            default:   alu_result = src_a + src_b;
        endcase
    end

    // BEQ on equal, BNE on not equal
    assign taken      = i_branch && ((src_a == rs2_val) != i_branch_ne);
    assign o_redirect = taken || i_jump;
    assign o_target   = i_pc + i_imm[P_ADDR_WIDTH-1:0];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_regwrite_r <= 1'b0;
            o_memwrite_r <= 1'b0;
        end else begin
            o_regwrite_r <= i_regwrite;
            o_memwrite_r <= i_memwrite;
        end
    end

    always_ff @(posedge i_clk) begin
        o_alu_result_r <= alu_result;
        o_store_data_r <= rs2_val;
        o_rd_addr_r    <= i_rd_addr;
        o_resultsrc_r  <= i_resultsrc;
        o_pc4_r        <= XLEN'(i_pc4);
    end

    // The slot behind a redirect is flushed, so it cannot redirect again
    assert property (@(posedge i_clk) disable iff (i_rst)
        o_redirect |=> !o_redirect);

endmodule

`default_nettype wire

// ==== rtl/result_stage.sv ====
// Result stage: data memory access, writeback selection and forwarding source
`timescale 1ns/1ps
`default_nettype none

module result_stage #(
    parameter int P_DMEM_ADDR_WIDTH = 11
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic [rv_pkg::XLEN-1:0]       i_alu_result_r,
    input  logic [rv_pkg::XLEN-1:0]       i_store_data_r,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd_addr_r,
    input  logic                          i_regwrite_r,
    input  logic                          i_memwrite_r,
    input  rv_pkg::result_src_t           i_resultsrc_r,
    input  logic [rv_pkg::XLEN-1:0]       i_pc4_r,
    output logic                          o_dmem_we,
    output logic [P_DMEM_ADDR_WIDTH-1:0]  o_dmem_addr,
    output logic [rv_pkg::XLEN-1:0]       o_dmem_wdata,
    input  logic [rv_pkg::XLEN-1:0]       i_dmem_rdata,
    output logic                          o_wb_we,
    output logic [rv_pkg::REG_ADDR_W-1:0] o_wb_rd,
    output logic [rv_pkg::XLEN-1:0]       o_wb_data
);
    import rv_pkg::*;

    assign o_dmem_we    = i_memwrite_r;
    assign o_dmem_addr  = i_alu_result_r[P_DMEM_ADDR_WIDTH-1:0];
    assign o_dmem_wdata = i_store_data_r;

    always_comb begin
        case (i_resultsrc_r)
            RES_MEM: o_wb_data = i_dmem_rdata;
            RES_PC4: o_wb_data = i_pc4_r;
            default: o_wb_data = i_alu_result_r;
        endcase
    end

    assign o_wb_we = i_regwrite_r;
    assign o_wb_rd = i_rd_addr_r;

    // Word accesses only
    assert property (@(posedge i_clk) disable iff (i_rst)
        (i_memwrite_r || (i_regwrite_r && i_resultsrc_r == RES_MEM))
            |-> (i_alu_result_r[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== rtl/riscv_core.sv ====
// Three-stage RV32I subset core with external instruction and data memory ports
`timescale 1ns/1ps
`default_nettype none

module riscv_core #(
    parameter int P_ADDR_WIDTH      = 11,
    parameter int P_DMEM_ADDR_WIDTH = 11
) (
    input  logic                         i_clk,
    input  logic                         i_rst,
    output logic [P_ADDR_WIDTH-1:0]      o_imem_addr,
    input  logic [rv_pkg::XLEN-1:0]      i_imem_rdata,
    output logic                         o_dmem_we,
    output logic [P_DMEM_ADDR_WIDTH-1:0] o_dmem_addr,
    output logic [rv_pkg::XLEN-1:0]      o_dmem_wdata,
    input  logic [rv_pkg::XLEN-1:0]      i_dmem_rdata
);
    import rv_pkg::*;

    // Decode/execute
    logic                    de_regwrite, de_memwrite, de_branch, de_branch_ne;
    logic                    de_jump, de_alusrc;
    alu_op_t                 de_aluop;
    result_src_t             de_resultsrc;
    logic [XLEN-1:0]         de_rs1_data, de_rs2_data, de_imm;
    logic [REG_ADDR_W-1:0]   de_rs1_addr, de_rs2_addr, de_rd_addr;
    logic [P_ADDR_WIDTH-1:0] de_pc, de_pc4;

    // Execute/result
    logic [XLEN-1:0]         er_alu_result, er_store_data, er_pc4;
    logic [REG_ADDR_W-1:0]   er_rd_addr;
    logic                    er_regwrite, er_memwrite;
    result_src_t             er_resultsrc;

    logic                    redirect;
    logic [P_ADDR_WIDTH-1:0] target;
    logic                    wb_we;
    logic [REG_ADDR_W-1:0]   wb_rd;
    logic [XLEN-1:0]         wb_data;

    decode_stage #(
        .P_ADDR_WIDTH (P_ADDR_WIDTH)
    ) u_decode_stage (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_redirect    (redirect),
        .i_target      (target),
        .o_imem_addr   (o_imem_addr),
        .i_imem_rdata  (i_imem_rdata),
        .i_wb_we       (wb_we),
        .i_wb_rd       (wb_rd),
        .i_wb_data     (wb_data),
        .o_regwrite_e  (de_regwrite),
        .o_memwrite_e  (de_memwrite),
        .o_branch_e    (de_branch),
        .o_branch_ne_e (de_branch_ne),
        .o_jump_e      (de_jump),
        .o_alusrc_e    (de_alusrc),
        .o_aluop_e     (de_aluop),
        .o_resultsrc_e (de_resultsrc),
        .o_rs1_data_e  (de_rs1_data),
        .o_rs2_data_e  (de_rs2_data),
        .o_rs1_addr_e  (de_rs1_addr),
        .o_rs2_addr_e  (de_rs2_addr),
        .o_rd_addr_e   (de_rd_addr),
        .o_imm_e       (de_imm),
        .o_pc_e        (de_pc),
        .o_pc4_e       (de_pc4)
    );

    execute_stage #(
        .P_ADDR_WIDTH (P_ADDR_WIDTH)
    ) u_execute_stage (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_regwrite     (de_regwrite),
        .i_memwrite     (de_memwrite),
        .i_branch       (de_branch),
        .i_branch_ne    (de_branch_ne),
        .i_jump         (de_jump),
        .i_alusrc       (de_alusrc),
        .i_aluop        (de_aluop),
        .i_resultsrc    (de_resultsrc),
        .i_rs1_data     (de_rs1_data),
        .i_rs2_data     (de_rs2_data),
        .i_rs1_addr     (de_rs1_addr),
        .i_rs2_addr     (de_rs2_addr),
        .i_rd_addr      (de_rd_addr),
        .i_imm          (de_imm),
        .i_pc           (de_pc),
        .i_pc4          (de_pc4),
        .i_fwd_we       (wb_we),
        .i_fwd_rd       (wb_rd),
        .i_fwd_data     (wb_data),
        .o_redirect     (redirect),
        .o_target       (target),
        .o_alu_result_r (er_alu_result),
        .o_store_data_r (er_store_data),
        .o_rd_addr_r    (er_rd_addr),
        .o_regwrite_r   (er_regwrite),
        .o_memwrite_r   (er_memwrite),
        .o_resultsrc_r  (er_resultsrc),
        .o_pc4_r        (er_pc4)
    );

    result_stage #(
        .P_DMEM_ADDR_WIDTH (P_DMEM_ADDR_WIDTH)
    ) u_result_stage (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_alu_result_r (er_alu_result),
        .i_store_data_r (er_store_data),
        .i_rd_addr_r    (er_rd_addr),
        .i_regwrite_r   (er_regwrite),
        .i_memwrite_r   (er_memwrite),
        .i_resultsrc_r  (er_resultsrc),
        .i_pc4_r        (er_pc4),
        .o_dmem_we      (o_dmem_we),
        .o_dmem_addr    (o_dmem_addr),
        .o_dmem_wdata   (o_dmem_wdata),
        .i_dmem_rdata   (i_dmem_rdata),
        .o_wb_we        (wb_we),
        .o_wb_rd        (wb_rd),
        .o_wb_data      (wb_data)
    );

endmodule

`default_nettype wire

// ==== verification/tb_riscv_core.sv ====
// Directed testbench for the three-stage RV32I subset core with memory models
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core;
    import rv_pkg::*;

    localparam logic [11:0] MARKER = 12'h7FC;
    localparam logic [11:0] POISON = 12'h600;

    logic        i_clk;
    logic        i_rst;
    logic [10:0] o_imem_addr;
    logic [31:0] i_imem_rdata;
    logic        o_dmem_we;
    logic [10:0] o_dmem_addr;
    logic [31:0] o_dmem_wdata;
    logic [31:0] i_dmem_rdata;

    logic [31:0] imem [0:511];
    logic [31:0] dmem [0:511];
    logic [31:0] prog [$];
    logic [10:0] st_addr_q [$];
    logic [31:0] st_data_q [$];
    integer      seed = 98365;
    int          checks;
    int          errors;

    riscv_core #(
        .P_ADDR_WIDTH      (11),
        .P_DMEM_ADDR_WIDTH (11)
    ) i_riscv_core (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .o_imem_addr  (o_imem_addr),
        .i_imem_rdata (i_imem_rdata),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .i_dmem_rdata (i_dmem_rdata)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // Both memories read combinationally
    assign i_imem_rdata = imem[o_imem_addr[10:2]];
    assign i_dmem_rdata = dmem[o_dmem_addr[10:2]];

    // Data memory, filled once and written at the rising edge
    initial begin
        for (int i = 0; i < 512; i++) begin
            dmem[i] <= {16'hC3A5, 16'(i)};
        end
        forever begin
            @(posedge i_clk);
            if (o_dmem_we === 1'b1) begin
                dmem[o_dmem_addr[10:2]] <= o_dmem_wdata;
            end
        end
    end

    // Store record, sampled mid-cycle
    always @(negedge i_clk) begin
        if (o_dmem_we === 1'b1) begin
            st_addr_q.push_back(o_dmem_addr);
            st_data_q.push_back(o_dmem_wdata);
        end
    end

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_RTYPE};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] upper, input logic [4:0] rd);
        return {upper, rd, OPC_LUI};
    endfunction

    function automatic logic find_store(input logic [10:0] addr, output logic [31:0] data);
        logic found;
        found = 1'b0;
        data  = '0;
        foreach (st_addr_q[i]) begin
            if (st_addr_q[i] == addr) begin
                found = 1'b1;
                data  = st_data_q[i];
            end
        end
        return found;
    endfunction

    task automatic put(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // LUI plus ADDI, upper part rounded for the sign of the low part
    task automatic set_reg(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800;
        put(u_type(hi[31:12], rd));
        put(i_type(value[11:0], rd, 3'b000, rd, OPC_ITYPE));
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t: %s: got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic expect_store(input logic [10:0] addr, input logic [31:0] value,
                                input string what);
        logic [31:0] data;
        if (!find_store(addr, data)) begin
            checks++;
            errors++;
            $display("No store to address 0x%h was seen during %s", addr, what);
        end else begin
            check_equal(data, value, what);
        end
    endtask

    task automatic expect_no_store(input logic [10:0] addr, input string what);
        logic [31:0] data;
        checks++;
        if (find_store(addr, data)) begin
            errors++;
            $display("A flushed store reached address 0x%h during %s", addr, what);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < 512; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
        end
    endtask

    task automatic apply_reset();
        int c;
        @(negedge i_clk);
        i_rst = 1'b1;
        load_program();
        for (c = 0; c < 3; c++) begin
            @(posedge i_clk);
            if (c == 0) begin
                st_addr_q.delete();
                st_data_q.delete();
            end
            @(negedge i_clk);
            check_equal(32'(o_dmem_we), 32'h0, "store enable in reset");
            check_equal(32'(o_imem_addr), 32'h0, "fetch address in reset");
        end
        i_rst = 1'b0;
        check_equal(32'(o_imem_addr), 32'h0, "fetch address after reset");
        @(negedge i_clk);
        check_equal(32'(o_dmem_we), 32'h0, "store enable after reset");
    endtask

    task automatic run_program(input string name);
        int          cycles;
        logic        seen;
        logic [31:0] data;
        put(s_type(MARKER, 0, 0));
        apply_reset();
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 200) begin
            @(posedge i_clk);
            cycles++;
            seen = find_store(MARKER[10:0], data);
        end
        if (!seen) begin
            errors++;
            $display("Timeout: %s never stored to the marker address in 200 cycles", name);
        end
    endtask

    task automatic test_alu_chain();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] x [3:16];
        logic [11:0] i1, i2, i3, i4;
        logic [4:0]  sh1, sh2;
        a   = $random(seed);
        b   = $random(seed);
        i1  = 12'($random(seed));
        i2  = 12'($random(seed));
        i3  = 12'($random(seed));
        i4  = 12'($random(seed));
        sh1 = 5'($random(seed));
        sh2 = 5'($random(seed));
        prog.delete();
        set_reg(1, a);
        set_reg(2, b);
        // Each step reads the one before it
        put(r_type(7'h00, 2, 1, 3'b000, 3));
        put(r_type(7'h20, 1, 3, 3'b000, 4));
        put(r_type(7'h00, 3, 4, 3'b100, 5));
        put(r_type(7'h00, 4, 5, 3'b110, 6));
        put(r_type(7'h00, 1, 6, 3'b010, 7));
        put(i_type({7'h00, sh1}, 6, 3'b001, 8, OPC_ITYPE));
        put(i_type({7'h00, sh2}, 8, 3'b101, 9, OPC_ITYPE));
        put(i_type(i1, 9, 3'b000, 10, OPC_ITYPE));
        put(i_type(i2, 10, 3'b111, 11, OPC_ITYPE));
        put(i_type(i3, 11, 3'b110, 12, OPC_ITYPE));
        put(i_type(i4, 12, 3'b100, 13, OPC_ITYPE));
        put(r_type(7'h00, 5, 13, 3'b111, 14));
        put(r_type(7'h00, 2, 14, 3'b001, 15));
        put(r_type(7'h00, 1, 15, 3'b101, 16));
        for (int k = 3; k <= 16; k++) begin
            put(s_type(12'(256 + 4 * k), 5'(k), 0));
        end
        run_program("ALU chain");
        x[3]  = a + b;
        x[4]  = x[3] - a;
        x[5]  = x[4] ^ x[3];
        x[6]  = x[5] | x[4];
        x[7]  = 32'($signed(x[6]) < $signed(a));
        x[8]  = x[6] << sh1;
        x[9]  = x[8] >> sh2;
        x[10] = x[9] + sext12(i1);
        x[11] = x[10] & sext12(i2);
        x[12] = x[11] | sext12(i3);
        x[13] = x[12] ^ sext12(i4);
        x[14] = x[13] & x[5];
        x[15] = x[14] << b[4:0];
        x[16] = x[15] >> a[4:0];
        for (int k = 3; k <= 16; k++) begin
            expect_store(11'(256 + 4 * k), x[k], "ALU chain");
        end
    endtask

    task automatic test_load_use();
        logic [31:0] c;
        logic [11:0] imm;
        c   = $random(seed);
        imm = 12'($random(seed));
        prog.delete();
        set_reg(1, c);
        put(s_type(12'h200, 1, 0));
        put(i_type(12'h200, 0, 3'b010, 2, OPC_LOAD));
        put(i_type(imm, 2, 3'b000, 3, OPC_ITYPE));
        put(s_type(12'h204, 3, 0));
        run_program("load use");
        expect_store(11'h200, c, "load use, stored word");
        expect_store(11'h204, c + sext12(imm), "load use, loaded word plus immediate");
    endtask

    task automatic test_branches();
        logic [31:0] e;
        e = $random(seed);
        prog.delete();
        set_reg(1, e);
        set_reg(2, e);
        put(i_type(12'h001, 1, 3'b100, 3, OPC_ITYPE));
        // Taken BEQ, then taken BNE, each over a poison store
        put(b_type(13'd8, 2, 1, 3'b000));
        put(s_type(POISON, 1, 0));
        put(s_type(12'h400, 1, 0));
        put(b_type(13'd8, 3, 1, 3'b001));
        put(s_type(POISON, 1, 0));
        put(s_type(12'h404, 3, 0));
        // Not taken, the next store must run
        put(b_type(13'd8, 3, 1, 3'b000));
        put(s_type(12'h408, 2, 0));
        put(b_type(13'd8, 2, 1, 3'b001));
        put(s_type(12'h40C, 3, 0));
        run_program("branches");
        expect_no_store(POISON[10:0], "branches");
        expect_store(11'h400, e, "BEQ taken");
        expect_store(11'h404, e ^ 32'h1, "BNE taken");
        expect_store(11'h408, e, "BEQ not taken");
        expect_store(11'h40C, e ^ 32'h1, "BNE not taken");
    endtask

    task automatic test_jal();
        logic [31:0] jal_pc;
        prog.delete();
        put(i_type(12'h011, 0, 3'b000, 1, OPC_ITYPE));
        jal_pc = 32'(4 * prog.size());
        put(j_type(21'd12, 5));
        put(s_type(POISON, 1, 0));
        put(s_type(POISON, 1, 0));
        put(s_type(12'h500, 5, 0));
        run_program("JAL");
        expect_no_store(POISON[10:0], "JAL");
        expect_store(11'h500, jal_pc + 32'd4, "JAL link value");
    endtask

    task automatic test_x0_writes();
        logic [31:0] d;
        d = $random(seed);
        prog.delete();
        set_reg(1, d);
        put(i_type(12'h055, 1, 3'b000, 0, OPC_ITYPE));
        put(r_type(7'h00, 1, 1, 3'b000, 0));
        put(i_type(12'h007, 0, 3'b000, 4, OPC_ITYPE));
        put(s_type(12'h300, 0, 0));
        put(s_type(12'h304, 4, 0));
        run_program("x0 writes");
        expect_store(11'h300, 32'h0, "store of x0");
        expect_store(11'h304, 32'h7, "x0 read right after a write to x0");
    endtask

    initial begin
        i_rst  = 1'b1;
        checks = 0;
        errors = 0;
        prog.delete();
        load_program();
        test_alu_chain();
        test_load_use();
        test_branches();
        test_jal();
        test_x0_writes();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/rv_pkg.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/riscv_core.sv
verification/tb_riscv_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_riscv_core
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Result: FAILED
PASS_MSG  = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
